/* hw/hub75_panel_pkg.sv */
////////////////////
// panel geometry and pixel types, 16x16 panel at 1/8 scan
// PANEL_HEIGHT must be twice SCAN_ROWS and sizes powers of two
////////////////////
package hub75_panel_pkg;

    localparam int PANEL_WIDTH  = 16;
    localparam int PANEL_HEIGHT = 16;
    localparam int SCAN_ROWS    = PANEL_HEIGHT / 2;  // top and bottom halves shift together
    localparam int COLOR_BITS   = 4;                 // also the number of bit planes

    localparam int COL_ADDR_BITS  = $clog2(PANEL_WIDTH);
    localparam int ROW_ADDR_BITS  = $clog2(PANEL_HEIGHT);
    localparam int SCAN_ADDR_BITS = $clog2(SCAN_ROWS);

    typedef logic [COL_ADDR_BITS-1:0]  col_addr_t;
    typedef logic [ROW_ADDR_BITS-1:0]  row_addr_t;
    typedef logic [SCAN_ADDR_BITS-1:0] scan_addr_t;
    typedef logic [1:0]                plane_t;
    typedef logic [COLOR_BITS-1:0]     plane_mask_t;

    typedef struct packed {
        logic [COLOR_BITS-1:0] red;
        logic [COLOR_BITS-1:0] green;
        logic [COLOR_BITS-1:0] blue;
    } pixel_t;

    // red is bit 2, blue bit 0
    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } rgb_t;

    typedef struct packed {
        row_addr_t row;
        col_addr_t col;
    } pixel_addr_t;

    typedef struct packed {
        rgb_t       rgb_top;
        rgb_t       rgb_bottom;
        scan_addr_t row_addr;
        logic       clk_pixel;
        logic       latch;
        logic       oe_n;       // low lights the latched row
    } hub75_out_t;

endpackage

/* hw/hub75_ctrl_pkg.sv */
////////////////////
// command stream opcodes and write records
// argument bytes follow the opcode with no framing or checksum
////////////////////
package hub75_ctrl_pkg;

    // x, y, red<<4|green, blue
    localparam logic [7:0] OP_PIXEL    = 8'h50;
    localparam logic [7:0] OP_PLANES   = 8'h42;  // plane enable mask
    localparam logic [7:0] OP_CHANNELS = 8'h43;  // rgb mask, red in bit 2
    localparam logic [7:0] OP_ONTIME   = 8'h54;  // base on-time in cycles

    typedef struct packed {
        logic [7:0] data;
        logic       valid;  // one-cycle strobe
    } rx_byte_t;

    typedef struct packed {
        logic                         we;
        hub75_panel_pkg::pixel_addr_t addr;
        hub75_panel_pkg::pixel_t      pixel;
    } fb_write_t;

    typedef enum logic [1:0] {
        CFG_PLANES,
        CFG_CHANNELS,
        CFG_ONTIME
    } cfg_sel_t;

    typedef struct packed {
        logic       strobe;
        cfg_sel_t   sel;
        logic [7:0] data;
    } cfg_write_t;

    typedef struct packed {
        hub75_panel_pkg::plane_mask_t planes;
        hub75_panel_pkg::rgb_t        channels;
        logic [7:0]                   ontime;
    } cfg_t;

    localparam cfg_t CFG_RESET = '{planes: '1, channels: '1, ontime: 8'd4};

endpackage

/* hw/uart_byte_rx.sv */
////////////////////
// 8N1 receiver, TICKS_PER_BIT of at least 4
// framing errors drop the byte silently
////////////////////
`timescale 1ns/1ps

module uart_byte_rx #(
    parameter int TICKS_PER_BIT = 8
) (
    input  logic                      clk_root,
    input  logic                      arst_n,
    input  logic                      rx,
    output hub75_ctrl_pkg::rx_byte_t  rx_byte
);

    localparam int TW = $clog2(TICKS_PER_BIT);
    localparam logic [TW-1:0] TICK_LAST = TW'(TICKS_PER_BIT - 1);
    localparam logic [TW-1:0] TICK_HALF = TW'(TICKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP
    } state_t;

    state_t        state;
    logic          rx_meta;
    logic          rx_sync;
    logic [TW-1:0] tick_cnt;
    logic [2:0]    bit_cnt;
    logic [7:0]    shift_q;
    logic          valid_q;

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta  <= 1'b1;  // line idles high
            rx_sync  <= 1'b1;
            state    <= S_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            valid_q  <= 1'b0;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            valid_q <= 1'b0;
            tick_cnt <= tick_cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    tick_cnt <= '0;
                    if (!rx_sync) state <= S_START;
                end
                S_START: begin
                    // recheck in the middle of the start bit, glitches go back to idle
                    if (tick_cnt == TICK_HALF) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_sync ? S_IDLE : S_DATA;
                    end
                end
                S_DATA: begin
                    if (tick_cnt == TICK_LAST) begin
                        tick_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= S_STOP;
                    end
                end
                S_STOP: begin
                    if (tick_cnt == TICK_LAST) begin
                        valid_q <= rx_sync;  // low stop bit means no strobe
                        state   <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk_root) begin
        if (state == S_DATA && tick_cnt == TICK_LAST) shift_q <= {rx_sync, shift_q[7:1]};
    end

    assign rx_byte = '{data: shift_q, valid: valid_q};

endmodule

/* hw/cmd_parser.sv */
////////////////////
// opcode parser, one command at a time
// unknown opcodes are skipped and parsing resyncs on the next byte
////////////////////
`timescale 1ns/1ps

module cmd_parser (
    input  logic                        clk_root,
    input  logic                        arst_n,
    input  hub75_ctrl_pkg::rx_byte_t    rx_byte,
    output hub75_ctrl_pkg::fb_write_t   fb_write,
    output hub75_ctrl_pkg::cfg_write_t  cfg_write
);

    import hub75_panel_pkg::*;
    import hub75_ctrl_pkg::*;

    typedef enum logic [2:0] {
        P_IDLE,
        P_X,
        P_Y,
        P_RG,
        P_B,
        P_ARG  // single argument of a config opcode
    } state_t;

    state_t      state;
    logic        we_q;
    logic        strobe_q;
    pixel_addr_t addr_q;
    pixel_t      pixel_q;
    cfg_sel_t    sel_q;
    logic [7:0]  data_q;

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            state    <= P_IDLE;
            we_q     <= 1'b0;
            strobe_q <= 1'b0;
        end else begin
            we_q     <= 1'b0;
            strobe_q <= 1'b0;
            if (rx_byte.valid) begin
                case (state)
                    P_IDLE: begin
                        case (rx_byte.data)
                            OP_PIXEL:                          state <= P_X;
                            OP_PLANES, OP_CHANNELS, OP_ONTIME: state <= P_ARG;
                            default:                           state <= P_IDLE;
                        endcase
                    end
                    P_X:  state <= P_Y;
                    P_Y:  state <= P_RG;
                    P_RG: state <= P_B;
                    P_B: begin
                        state <= P_IDLE;
                        we_q  <= 1'b1;
                    end
                    P_ARG: begin
                        state    <= P_IDLE;
                        strobe_q <= 1'b1;
                    end
                    default: state <= P_IDLE;
                endcase
            end
        end
    end

    // argument capture, qualified by the strobes above
    always_ff @(posedge clk_root) begin
        if (rx_byte.valid) begin
            case (state)
                P_IDLE: begin
                    if (rx_byte.data == OP_PLANES) sel_q <= CFG_PLANES;
                    if (rx_byte.data == OP_CHANNELS) sel_q <= CFG_CHANNELS;
                    if (rx_byte.data == OP_ONTIME) sel_q <= CFG_ONTIME;
                end
                P_X:  addr_q.col <= rx_byte.data[COL_ADDR_BITS-1:0];
                P_Y:  addr_q.row <= rx_byte.data[ROW_ADDR_BITS-1:0];
                P_RG: begin
                    pixel_q.red   <= rx_byte.data[7:4];
                    pixel_q.green <= rx_byte.data[3:0];
                end
                P_B:   pixel_q.blue <= rx_byte.data[3:0];  // high nibble ignored
                P_ARG: data_q <= rx_byte.data;
                default: ;
            endcase
        end
    end

    assign fb_write  = '{we: we_q, addr: addr_q, pixel: pixel_q};
    assign cfg_write = '{strobe: strobe_q, sel: sel_q, data: data_q};

endmodule

/* hw/config_regs.sv */
////////////////////
// display settings, new value visible the cycle after the strobe
////////////////////
`timescale 1ns/1ps

module config_regs (
    input  logic                        clk_root,
    input  logic                        arst_n,
    input  hub75_ctrl_pkg::cfg_write_t  cfg_write,
    output hub75_ctrl_pkg::cfg_t        cfg
);

    import hub75_panel_pkg::*;
    import hub75_ctrl_pkg::*;

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            cfg <= CFG_RESET;
        end else if (cfg_write.strobe) begin
            case (cfg_write.sel)
                CFG_PLANES:   cfg.planes   <= cfg_write.data[COLOR_BITS-1:0];
                CFG_CHANNELS: cfg.channels <= cfg_write.data[2:0];  // r g b from bit 2 down
                CFG_ONTIME:   cfg.ontime   <= cfg_write.data;
                default: ;
            endcase
        end
    end

endmodule

/* hw/frame_ram.sv */
////////////////////
// pixel memory, contents undefined until written
// a read of the address being written returns the old pixel
////////////////////
`timescale 1ns/1ps

module frame_ram (
    input  logic                          clk_root,
    input  hub75_ctrl_pkg::fb_write_t     fb_write,
    input  hub75_panel_pkg::pixel_addr_t  rd_addr,
    output hub75_panel_pkg::pixel_t       rd_pixel
);

    import hub75_panel_pkg::*;

    pixel_t mem [PANEL_WIDTH*PANEL_HEIGHT];  // indexed by {row, col}

    always_ff @(posedge clk_root) begin
        if (fb_write.we) mem[fb_write.addr] <= fb_write.pixel;
    end

    always_ff @(posedge clk_root) begin
        rd_pixel <= mem[rd_addr];
    end

endmodule

/* hw/matrix_scan.sv */
////////////////////
// bit-plane scanner, panel blanked while a row shifts
// outputs are registered and lag the sequencer state by one cycle
////////////////////
`timescale 1ns/1ps

module matrix_scan (
    input  logic                          clk_root,
    input  logic                          arst_n,
    input  hub75_ctrl_pkg::cfg_t          cfg,
    output hub75_panel_pkg::pixel_addr_t  rd_addr,
    input  hub75_panel_pkg::pixel_t       rd_pixel,
    output hub75_panel_pkg::hub75_out_t   panel
);

    import hub75_panel_pkg::*;
    import hub75_ctrl_pkg::*;

    localparam int ON_BITS = 8 + COLOR_BITS - 1;  // base on-time << last plane
    localparam col_addr_t  COL_LAST   = col_addr_t'(PANEL_WIDTH - 1);
    localparam scan_addr_t ROW_LAST   = scan_addr_t'(SCAN_ROWS - 1);
    localparam plane_t     PLANE_LAST = plane_t'(COLOR_BITS - 1);

    typedef enum logic [1:0] {
        PH_SHIFT,
        PH_LATCH,
        PH_SHOW
    } phase_t;

    phase_t             phase;
    logic [1:0]         slot;  // cycle within a column
    col_addr_t          col;
    plane_t             plane;
    scan_addr_t         row;
    logic [ON_BITS-1:0] on_cnt;
    logic [ON_BITS-1:0] on_len;
    logic               plane_done;
    pixel_t             top_q;

    function automatic rgb_t plane_bits(input pixel_t px, input plane_t pl, input cfg_t c);
        rgb_t bits;
        bits.red   = px.red[pl] & c.planes[pl] & c.channels.red;
        bits.green = px.green[pl] & c.planes[pl] & c.channels.green;
        bits.blue  = px.blue[pl] & c.planes[pl] & c.channels.blue;
        return bits;
    endfunction

    assign on_len = ON_BITS'(cfg.ontime) << plane;
    // zero on-time skips the display phase
    assign plane_done = (phase == PH_LATCH && on_len == '0) ||
                        (phase == PH_SHOW && on_cnt == ON_BITS'(1));

    // slot 0 top half, slot 1 bottom half
    assign rd_addr.col = col;
    assign rd_addr.row = slot[0] ? row_addr_t'(row) + row_addr_t'(SCAN_ROWS) : row_addr_t'(row);

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            phase  <= PH_SHIFT;
            slot   <= '0;
            col    <= '0;
            plane  <= '0;
            row    <= '0;
            on_cnt <= '0;
        end else begin
            case (phase)
                PH_SHIFT: begin
                    slot <= slot + 2'd1;
                    if (slot == 2'd3) begin
                        col <= (col == COL_LAST) ? '0 : col + col_addr_t'(1);
                        if (col == COL_LAST) phase <= PH_LATCH;
                    end
                end
                PH_LATCH: begin
                    on_cnt <= on_len;  // on-time sampled here
                    phase  <= plane_done ? PH_SHIFT : PH_SHOW;
                end
                PH_SHOW: begin
                    on_cnt <= on_cnt - ON_BITS'(1);
                    if (plane_done) phase <= PH_SHIFT;
                end
                default: phase <= PH_SHIFT;
            endcase

            // planes inner, rows outer
            if (plane_done) begin
                plane <= (plane == PLANE_LAST) ? '0 : plane + plane_t'(1);
                if (plane == PLANE_LAST) row <= (row == ROW_LAST) ? '0 : row + scan_addr_t'(1);
            end
        end
    end

    always_ff @(posedge clk_root) begin
        if (phase == PH_SHIFT && slot == 2'd1) top_q <= rd_pixel;
    end

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            panel <= '{rgb_top: '0, rgb_bottom: '0, row_addr: '0,
                       clk_pixel: 1'b0, latch: 1'b0, oe_n: 1'b1};
        end else begin
            panel.clk_pixel <= (phase == PH_SHIFT) && (slot == 2'd3);
            panel.latch     <= (phase == PH_LATCH);
            panel.oe_n      <= (phase != PH_SHOW);
            if (phase == PH_LATCH) panel.row_addr <= row;  // row just shifted
            if (phase == PH_SHIFT && slot == 2'd2) begin
                panel.rgb_top    <= plane_bits(top_q, plane, cfg);
                panel.rgb_bottom <= plane_bits(rd_pixel, plane, cfg);  // bottom read lands now
            end
        end
    end

endmodule

/* hw/hub75_top.sv */
////////////////////
// uart in, HUB75 out, single clock domain
// panel clock is clk_root / 4 while shifting
////////////////////
`timescale 1ns/1ps

module hub75_top #(
    parameter int TICKS_PER_BIT = 8
) (
    input  logic                         clk_root,
    input  logic                         arst_n,
    input  logic                         rx,
    output hub75_panel_pkg::hub75_out_t  panel
);

    import hub75_panel_pkg::*;
    import hub75_ctrl_pkg::*;

    rx_byte_t    rx_byte;
    fb_write_t   fb_write;
    cfg_write_t  cfg_write;
    cfg_t        cfg;
    pixel_addr_t rd_addr;
    pixel_t      rd_pixel;

    uart_byte_rx #(
        .TICKS_PER_BIT(TICKS_PER_BIT)
    ) u_rx (
        .clk_root(clk_root),
        .arst_n  (arst_n),
        .rx      (rx),
        .rx_byte (rx_byte)
    );

    cmd_parser u_parser (
        .clk_root (clk_root),
        .arst_n   (arst_n),
        .rx_byte  (rx_byte),
        .fb_write (fb_write),
        .cfg_write(cfg_write)
    );

    config_regs u_cfg (
        .clk_root (clk_root),
        .arst_n   (arst_n),
        .cfg_write(cfg_write),
        .cfg      (cfg)
    );

    frame_ram u_ram (
        .clk_root(clk_root),
        .fb_write(fb_write),
        .rd_addr (rd_addr),
        .rd_pixel(rd_pixel)
    );

    matrix_scan u_scan (
        .clk_root(clk_root),
        .arst_n  (arst_n),
        .cfg     (cfg),
        .rd_addr (rd_addr),
        .rd_pixel(rd_pixel),
        .panel   (panel)
    );

endmodule

/* verification/hub75_props.sv */
////////////////////
// panel output protocol checks, bound into every hub75_top
////////////////////
`timescale 1ns/1ps

module hub75_props (
    input logic                        clk_root,
    input logic                        arst_n,
    input hub75_panel_pkg::hub75_out_t panel
);

    int fail_count = 0;  // failed assertions so far

    // the row must be dark while the latch copies the shift register
    latch_dark: assert property (@(posedge clk_root) disable iff (!arst_n)
        panel.latch |-> panel.oe_n)
        else begin
            fail_count++;
            $error("latch high while oe_n low");
        end

    latch_pulse: assert property (@(posedge clk_root) disable iff (!arst_n)
        panel.latch |=> !panel.latch)
        else begin
            fail_count++;
            $error("latch held high for more than one cycle");
        end

    // shifting only happens while blanked
    shift_dark: assert property (@(posedge clk_root) disable iff (!arst_n)
        $rose(panel.clk_pixel) |-> panel.oe_n)
        else begin
            fail_count++;
            $error("clk_pixel rose while oe_n low");
        end

    reset_idle: assert property (@(posedge clk_root)
        $rose(arst_n) |-> panel.oe_n && !panel.latch && !panel.clk_pixel)
        else begin
            fail_count++;
            $error("panel outputs not idle after reset release");
        end

endmodule

bind hub75_top hub75_props u_props (
    .clk_root(clk_root),
    .arst_n  (arst_n),
    .panel   (panel)
);

/* verification/hub75_tb.sv */
////////////////////
// directed tests of hub75_top at 8 clocks per uart bit
// frame capture syncs on the last plane of scan row 7, so on-time must be nonzero
////////////////////
`timescale 1ns/1ps

module hub75_tb;

    import hub75_panel_pkg::*;
    import hub75_ctrl_pkg::*;

    localparam int BIT_CYCLES  = 8;
    localparam int PIXEL_BYTES = 5;
    // full frame, 14 config bytes, one unknown opcode and one more pixel
    localparam int BYTES_SENT = PANEL_WIDTH * PANEL_HEIGHT * PIXEL_BYTES + 14 + 1 + PIXEL_BYTES;
    localparam int FRAMES_CAPTURED = 2 * 6 + 1;  // sync plus capture, six checks, first latch

    function automatic int frame_cycles(input int base);
        int sum;
        sum = 0;
        for (int p = 0; p < COLOR_BITS; p++) sum += PANEL_WIDTH * 4 + 1 + (base << p);
        return SCAN_ROWS * sum;
    endfunction

    localparam int TIMEOUT_CYCLES =
        (BYTES_SENT * 10 * BIT_CYCLES + FRAMES_CAPTURED * frame_cycles(4)) * 12 / 10;

    logic       clk_root;
    logic       arst_n;
    logic       rx;
    hub75_out_t panel;

    pixel_t     model_px [PANEL_WIDTH*PANEL_HEIGHT];  // row * width + col
    cfg_t       model_cfg;
    rgb_t       cap_top [SCAN_ROWS][COLOR_BITS][PANEL_WIDTH];
    rgb_t       cap_bot [SCAN_ROWS][COLOR_BITS][PANEL_WIDTH];
    scan_addr_t cap_row [SCAN_ROWS][COLOR_BITS];
    int         cap_on  [SCAN_ROWS][COLOR_BITS];
    int         err_cnt = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    int         cycle_cnt = 0;

    hub75_top #(.TICKS_PER_BIT(BIT_CYCLES)) uut (
        .clk_root(clk_root),
        .arst_n  (arst_n),
        .rx      (rx),
        .panel   (panel)
    );

    initial begin
        clk_root = 1'b0;
        forever #20 clk_root = ~clk_root;
    end

    always @(posedge clk_root) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the panel never reached the awaited event",
                     cycle_cnt);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_row(input string name, input scan_addr_t exp, input scan_addr_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_ontime(input string name, input int exp, input int act);
        if (act != exp) begin
            err_cnt++;
            $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // 8N1, lsb first, line held for one bit time per symbol
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] symbols;
        symbols = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk_root);
            rx <= symbols[i];
            repeat (BIT_CYCLES - 1) @(posedge clk_root);
        end
    endtask

    task automatic send_pixel(input int x, input int y, input pixel_t px);
        send_byte(OP_PIXEL);
        send_byte(8'(x));
        send_byte(8'(y));
        send_byte({px.red, px.green});
        send_byte({4'h0, px.blue});
        model_px[y * PANEL_WIDTH + x] = px;
        repeat (4) @(posedge clk_root);  // write lands two cycles after the stop bit
    endtask

    task automatic send_cfg(input logic [7:0] op, input logic [7:0] data);
        send_byte(op);
        send_byte(data);
        case (op)
            OP_PLANES:   model_cfg.planes   = data[COLOR_BITS-1:0];
            OP_CHANNELS: model_cfg.channels = data[2:0];
            OP_ONTIME:   model_cfg.ontime   = data;
            default: ;
        endcase
        repeat (4) @(posedge clk_root);
    endtask

    // colour bit at the plane, gated by plane and channel enables
    function automatic rgb_t expected_bits(input pixel_t px, input int pl);
        rgb_t bits;
        logic lit;
        lit = model_cfg.planes[pl];
        bits.red   = px.red[pl] && lit && model_cfg.channels.red;
        bits.green = px.green[pl] && lit && model_cfg.channels.green;
        bits.blue  = px.blue[pl] && lit && model_cfg.channels.blue;
        return bits;
    endfunction

    // call on the latch cycle, returns on the first cycle with oe_n high again
    task automatic measure_oe(output int len);
        len = 0;
        @(negedge clk_root);
        while (panel.oe_n == 1'b0) begin
            len++;
            @(negedge clk_root);
        end
    endtask

    task automatic wait_frame_start();
        int   len;
        logic found;
        found = 1'b0;
        while (!found) begin
            @(negedge clk_root);
            if (panel.latch && panel.row_addr == scan_addr_t'(SCAN_ROWS - 1)) begin
                measure_oe(len);
                found = (len == (int'(model_cfg.ontime) << (COLOR_BITS - 1)));
            end
        end
    endtask

    task automatic capture_frame();
        int   n;
        logic clk_prev;
        clk_prev = panel.clk_pixel;
        for (int r = 0; r < SCAN_ROWS; r++) begin
            for (int p = 0; p < COLOR_BITS; p++) begin
                n = 0;
                while (n < PANEL_WIDTH) begin
                    @(negedge clk_root);
                    if (panel.clk_pixel && !clk_prev) begin
                        cap_top[r][p][n] = panel.rgb_top;
                        cap_bot[r][p][n] = panel.rgb_bottom;
                        n++;
                    end
                    clk_prev = panel.clk_pixel;
                end
                while (!panel.latch) @(negedge clk_root);
                cap_row[r][p] = panel.row_addr;
                measure_oe(cap_on[r][p]);
                clk_prev = panel.clk_pixel;
            end
        end
    endtask

    task automatic check_frame();
        for (int r = 0; r < SCAN_ROWS; r++) begin
            for (int p = 0; p < COLOR_BITS; p++) begin
                check_row($sformatf("row_addr r%0d p%0d", r, p), scan_addr_t'(r), cap_row[r][p]);
                check_ontime($sformatf("oe_n low r%0d p%0d", r, p),
                             int'(model_cfg.ontime) << p, cap_on[r][p]);
                for (int c = 0; c < PANEL_WIDTH; c++) begin
                    check_rgb($sformatf("rgb_top r%0d p%0d c%0d", r, p, c),
                              expected_bits(model_px[r * PANEL_WIDTH + c], p), cap_top[r][p][c]);
                    check_rgb($sformatf("rgb_bottom r%0d p%0d c%0d", r, p, c),
                              expected_bits(model_px[(r + SCAN_ROWS) * PANEL_WIDTH + c], p),
                              cap_bot[r][p][c]);
                end
            end
        end
    endtask

    task automatic verify_frame();
        wait_frame_start();
        capture_frame();
        check_frame();
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_cnt == errs_before) begin
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s, %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic test_reset();
        int errs;
        errs = err_cnt;
        @(posedge clk_root);
        @(negedge clk_root);
        check_level("oe_n in reset", 1'b1, panel.oe_n);
        check_level("latch in reset", 1'b0, panel.latch);
        check_level("clk_pixel in reset", 1'b0, panel.clk_pixel);
        check_row("row_addr in reset", '0, panel.row_addr);
        check_rgb("rgb_top in reset", '0, panel.rgb_top);
        check_rgb("rgb_bottom in reset", '0, panel.rgb_bottom);
        @(posedge clk_root);
        arst_n <= 1'b1;
        @(negedge clk_root);
        check_level("oe_n after reset", 1'b1, panel.oe_n);
        check_level("latch after reset", 1'b0, panel.latch);
        check_level("clk_pixel after reset", 1'b0, panel.clk_pixel);
        while (!panel.latch) @(negedge clk_root);
        check_row("row_addr at first latch", '0, panel.row_addr);
        report_test("reset state", errs);
    endtask

    task automatic test_full_frame();
        int errs;
        errs = err_cnt;
        for (int y = 0; y < PANEL_HEIGHT; y++) begin
            for (int x = 0; x < PANEL_WIDTH; x++) send_pixel(x, y, pixel_t'(12'($urandom)));
        end
        verify_frame();
        report_test("full frame", errs);
    endtask

    task automatic test_plane_mask();
        int errs;
        errs = err_cnt;
        send_cfg(OP_PLANES, 8'($urandom % 15));  // at least one plane off
        verify_frame();
        send_cfg(OP_PLANES, 8'h0F);
        report_test("plane mask", errs);
    endtask

    task automatic test_channel_mask();
        int errs;
        errs = err_cnt;
        send_cfg(OP_CHANNELS, 8'h05);  // green off
        verify_frame();
        send_cfg(OP_CHANNELS, 8'h03);  // red off
        verify_frame();
        send_cfg(OP_CHANNELS, 8'h07);
        report_test("channel mask", errs);
    endtask

    task automatic test_ontime();
        int errs;
        errs = err_cnt;
        send_cfg(OP_ONTIME, 8'd3);
        verify_frame();
        send_cfg(OP_ONTIME, 8'd4);
        report_test("on-time", errs);
    endtask

    task automatic test_unknown_opcode();
        int errs;
        int x;
        int y;
        errs = err_cnt;
        x = $urandom % PANEL_WIDTH;
        y = $urandom % PANEL_HEIGHT;
        send_byte(8'h00);
        send_pixel(x, y, ~model_px[y * PANEL_WIDTH + x]);  // every bit changes
        verify_frame();
        report_test("unknown opcode", errs);
    endtask

    initial begin
        rx        = 1'b1;
        arst_n    = 1'b0;
        model_cfg = '{planes: 4'hF, channels: 3'b111, ontime: 8'd4};
        void'($urandom(56948));
        test_reset();
        test_full_frame();
        test_plane_mask();
        test_channel_mask();
        test_ontime();
        test_unknown_opcode();
        $display("tests run %0d, failed %0d, value errors %0d, assertion failures %0d",
                 tests_run, tests_failed, err_cnt, uut.u_props.fail_count);
        if (tests_failed == 0 && uut.u_props.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* hub75_top.f */
hw/hub75_panel_pkg.sv
hw/hub75_ctrl_pkg.sv
hw/uart_byte_rx.sv
hw/cmd_parser.sv
hw/config_regs.sv
hw/frame_ram.sv
hw/matrix_scan.sv
hw/hub75_top.sv
verification/hub75_props.sv
verification/hub75_tb.sv
